// File: Bender.yml
package:
  name: spi_apb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spiPkg.sv
      - hdl/spiFifo.sv
      - hdl/spiClockGen.sv
      - hdl/spiEngine.sv
      - hdl/spiRegs.sv
      - hdl/spiApb.sv
      - target: simulation
        files:
          - dv/spiApbTb.sv

// File: all.f
+incdir+hdl
hdl/spiPkg.sv
hdl/spiFifo.sv
hdl/spiClockGen.sv
hdl/spiEngine.sv
hdl/spiRegs.sv
hdl/spiApb.sv
dv/spiApbTb.sv

// File: dv/spiApbTb.sv
/*
  Testbench for the APB SPI master. SPIOut is looped back to SPIIn.
  Inputs change on the falling PCLK edge.
*/
`timescale 1ns/1ps
`include "spiApb_settings.svh"

module spiApbTb;

    logic               PCLK;
    logic               PRESETn;
    logic               PSEL, PENABLE, PWRITE;
    spiPkg::regAddr_t   PADDR;
    spiPkg::apbData_t   PWDATA;
    logic [3:0]         PSTRB;
    logic               PREADY;
    spiPkg::apbData_t   PRDATA;
    logic               SPIOut, SPIIn, SPICLK, SPIIntr;
    spiPkg::csVec_t     SPICS;

    logic [31:0]        lfsrState = 32'h7e94_9edb;
    int                 curDiv;                 // Divider the engine runs with
    string              curTest;
    spiPkg::spiByte_t   expQ[$];                // Expected RX bytes in send order
    spiPkg::spiByte_t   gotQ[$];                // Bytes read back from RXDATA

    assign SPIIn = SPIOut;                      // Single lane loopback

    spiApb i_spiApb (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PSTRB,
        .PREADY, .PRDATA, .SPIOut, .SPIIn, .SPICS, .SPICLK, .SPIIntr
    );

    initial begin
        PCLK = 1'b0;
        forever #20 PCLK = ~PCLK;               // 25 MHz
    end

    ////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkByte(input string name, input spiPkg::spiByte_t exp,
                             input spiPkg::spiByte_t act);
        if (act !== exp) abortRun($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkWord(input string name, input spiPkg::apbData_t exp,
                             input spiPkg::apbData_t act);
        if (act !== exp) abortRun($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkCs(input string name, input spiPkg::csVec_t exp,
                           input spiPkg::csVec_t act);
        if (act !== exp) abortRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) abortRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    endtask

    // Received bytes are matched in order against the reference values
    always @(negedge PCLK) begin
        if (gotQ.size() != 0) begin
            if (expQ.size() == 0) abortRun("A byte arrived in RXDATA that was never sent");
            else checkByte(curTest, expQ.pop_front(), gotQ.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};        // One step per bit
        end
    endtask

    // MSB-first keeps the top len bits and LSB-first the low len bits
    function automatic spiPkg::spiByte_t expectedRx(input spiPkg::spiByte_t tx,
                                                    input spiPkg::frameLen_t len,
                                                    input logic lsbFirst);
        spiPkg::spiByte_t mask;
        if (lsbFirst) mask = 8'hFF >> (8 - len);
        else mask = 8'hFF << (8 - len);
        return tx & mask;
    endfunction

    function automatic spiPkg::apbData_t fmtWord(input spiPkg::frameLen_t len, input logic lsb);
        return {12'b0, len, 13'b0, lsb, 2'b0};  // len in 19:16 and endian in bit 2
    endfunction

    // Setup, access, then one idle cycle so a pop settles before the next setup
    task automatic apbWrite(input spiPkg::regAddr_t addr, input spiPkg::apbData_t data);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = addr;
        PWDATA  = data;
        @(negedge PCLK);
        PENABLE = 1'b1;
        checkBit("PREADY write", 1'b1, PREADY);
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apbRead(input spiPkg::regAddr_t addr, output spiPkg::apbData_t data);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = addr;
        @(negedge PCLK);
        PENABLE = 1'b1;
        checkBit("PREADY read", 1'b1, PREADY);
        @(negedge PCLK);
        data    = PRDATA;                       // Captured at the setup edge
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic setDivider(input int div);
        apbWrite(`SPI_ADDR_SCKDIV, div);
        curDiv = div;
    endtask

    // Trail and InterCs take one tick each
    task automatic waitTicks(input int n);
        repeat (n * (curDiv + 1) + 2) @(negedge PCLK);
    endtask

    task automatic sendByte(input spiPkg::spiByte_t b, input spiPkg::frameLen_t len,
                            input logic lsb);
        expQ.push_back(expectedRx(b, len, lsb));
        apbWrite(`SPI_ADDR_TXDATA, b);
    endtask

    task automatic waitRxByte();
        spiPkg::apbData_t w;
        int tries;
        tries = 0;
        w = 32'h8000_0000;
        while (w[31] && tries < 40 * (curDiv + 2)) begin
            apbRead(`SPI_ADDR_RXDATA, w);       // Pops once the empty bit clears
            tries++;
        end
        if (w[31]) abortRun("Timeout while waiting for a byte in RXDATA");
        else gotQ.push_back(w[7:0]);
    endtask

    task automatic waitIntr(input logic level, input string name);
        int n;
        n = 0;
        while (SPIIntr !== level && n < 60 * (curDiv + 2)) begin
            @(negedge PCLK);
            n++;
        end
        if (SPIIntr !== level) begin
            abortRun($sformatf("Timeout: SPIIntr never went to %b in %s", level, name));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        spiPkg::apbData_t  w;
        spiPkg::spiByte_t  b;
        spiPkg::frameLen_t len;
        spiPkg::csVec_t    csDef;
        logic [31:0]       r;
        logic [1:0]        csId;
        logic              lsb, lastClk;
        int                n, edges;

        PRESETn = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PSTRB   = 4'hF;                         // Word writes only
        curDiv  = 3;
        curTest = "reset";
        repeat (16) @(negedge PCLK);
        PRESETn = 1'b1;

        // Reset values
        apbRead(`SPI_ADDR_SCKDIV, w);
        checkWord("reset SCKDIV", 32'd3, w);
        apbRead(`SPI_ADDR_CSDEF, w);
        checkWord("reset CSDEF", 32'hF, w);
        apbRead(`SPI_ADDR_FMT, w);
        checkWord("reset FMT", fmtWord(4'd8, 1'b0), w);
        checkCs("reset SPICS", 4'b1111, SPICS);
        checkBit("reset SPICLK", 1'b0, SPICLK);
        checkBit("reset SPIIntr", 1'b0, SPIIntr);

        // Loopback in all four modes with random divider, length and bit order
        for (int mode = 0; mode < 4; mode++) begin
            curTest = $sformatf("loopback mode %0d", mode);
            apbWrite(`SPI_ADDR_SCKMODE, mode);
            takeBits(3, r);
            setDivider(r);
            checkBit("sck idle level", mode[1], SPICLK);     // pol is SCKMODE bit 1
            for (int k = 0; k < 4; k++) begin
                takeBits(8, r);
                b = r[7:0];
                takeBits(3, r);
                len = {1'b0, r[2:0]} + 4'd1;    // 1 to 8 bits
                takeBits(1, r);
                lsb = r[0];
                apbWrite(`SPI_ADDR_FMT, fmtWord(len, lsb));
                sendByte(b, len, lsb);
                waitRxByte();
                waitTicks(3);                   // Engine back in CsIdle before new config
            end
        end

        // FIFO flags with a slow SCK so nothing pops during the burst
        curTest = "fifo flags";
        apbWrite(`SPI_ADDR_SCKMODE, 0);
        apbWrite(`SPI_ADDR_FMT, fmtWord(4'd8, 1'b0));
        setDivider(63);
        for (int k = 0; k < 9; k++) begin
            takeBits(8, r);
            if (k < 8) expQ.push_back(expectedRx(r[7:0], 4'd8, 1'b0));
            apbWrite(`SPI_ADDR_TXDATA, r[7:0]);     // Ninth one is dropped
        end
        apbRead(`SPI_ADDR_TXDATA, w);
        checkBit("tx full flag", 1'b1, w[31]);
        apbWrite(`SPI_ADDR_RXMARK, 7);          // IP bit 1 marks eight bytes
        n = 0;
        w = '0;
        while (!w[1] && n < 100 * (curDiv + 2)) begin
            apbRead(`SPI_ADDR_IP, w);
            n++;
        end
        if (!w[1]) abortRun("Timeout while waiting for the RX FIFO to fill");
        waitTicks(3);
        for (int k = 0; k < 8; k++) begin
            apbRead(`SPI_ADDR_RXDATA, w);
            checkBit("rx not empty", 1'b0, w[31]);
            gotQ.push_back(w[7:0]);
        end
        apbRead(`SPI_ADDR_RXDATA, w);
        checkBit("rx empty flag", 1'b1, w[31]);
        setDivider(3);

        // Chip selects in auto mode
        curTest = "chip select auto";
        takeBits(2, r);
        csId = r[1:0];
        takeBits(4, r);
        csDef = r[3:0];
        apbWrite(`SPI_ADDR_CSDEF, csDef);
        apbWrite(`SPI_ADDR_CSID, csId);
        apbWrite(`SPI_ADDR_CSMODE, 0);
        checkCs("cs idle", csDef, SPICS);
        takeBits(8, r);
        sendByte(r[7:0], 4'd8, 1'b0);
        n = 0;
        while (SPICS === csDef && n < 20 * (curDiv + 2)) begin
            @(negedge PCLK);
            n++;
        end
        if (SPICS === csDef) abortRun("Timeout: the chip select was never asserted");
        else checkCs("cs auto active", csDef ^ (4'b0001 << csId), SPICS);
        waitRxByte();
        waitTicks(3);

        // In off mode SPICS holds csDef for all 16 SCK edges
        curTest = "chip select off";
        apbWrite(`SPI_ADDR_CSMODE, 3);
        takeBits(8, r);
        sendByte(r[7:0], 4'd8, 1'b0);
        edges = 0;
        n = 0;
        lastClk = SPICLK;
        while (edges < 16 && n < 40 * (curDiv + 2)) begin
            @(negedge PCLK);
            checkCs("cs off", csDef, SPICS);
            if (SPICLK !== lastClk) edges++;
            lastClk = SPICLK;
            n++;
        end
        if (edges < 16) abortRun("Timeout: SPICLK stopped before the frame ended");
        waitRxByte();
        waitTicks(3);

        // Watermark interrupts
        curTest = "interrupts";
        apbWrite(`SPI_ADDR_TXMARK, 1);
        apbWrite(`SPI_ADDR_IE, 1);
        waitIntr(1'b1, "tx watermark");
        apbWrite(`SPI_ADDR_IE, 2);
        apbWrite(`SPI_ADDR_RXMARK, 0);
        checkBit("rx irq before data", 1'b0, SPIIntr);
        takeBits(8, r);
        sendByte(r[7:0], 4'd8, 1'b0);
        waitIntr(1'b1, "rx watermark");
        waitTicks(3);
        checkBit("rx irq held", 1'b1, SPIIntr);
        apbRead(`SPI_ADDR_RXDATA, w);
        checkBit("rx data present", 1'b0, w[31]);
        gotQ.push_back(w[7:0]);
        waitIntr(1'b0, "rx read");

        // Let the compare process catch up
        n = 0;
        while (gotQ.size() != 0 && n < 100) begin
            @(negedge PCLK);
            n++;
        end
        if (gotQ.size() == 0 && expQ.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun($sformatf("%0d sent bytes were never matched", expQ.size()));
        end
    end

endmodule

// File: hdl/spiApb.sv
/*
  APB SPI master, one data lane, four chip selects.
  PREADY is tied high and PSTRB is ignored, so use word accesses only.
  Delays between CS and SCK are fixed at one half SCK period.
*/
`timescale 1ns/1ps

module spiApb (
    input  logic             PCLK,
    input  logic             PRESETn,
    input  logic             PSEL,
    input  logic             PENABLE,
    input  logic             PWRITE,
    input  spiPkg::regAddr_t PADDR,
    input  spiPkg::apbData_t PWDATA,
    input  logic [3:0]       PSTRB,     // Byte lanes not supported
    output logic             PREADY,
    output spiPkg::apbData_t PRDATA,
    output logic             SPIOut,
    input  logic             SPIIn,
    output spiPkg::csVec_t   SPICS,
    output logic             SPICLK,
    output logic             SPIIntr
);

    spiPkg::spiCfg_t    cfgLocked;          // Snapshot used by the engine
    spiPkg::fifoPush_t  txPush, rxPush;
    spiPkg::spiByte_t   txData, rxData;
    spiPkg::fifoLevel_t txLevel, rxLevel;
    logic               txPop, rxPop;
    logic               txEmpty;
    logic               tick;               // Half SCK period strobe
    logic               idle;

    assign PREADY = 1'b1;   // Zero wait states

    spiRegs uRegs (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA,
        .txLevel, .rxLevel, .rxData, .idle,
        .txPush, .rxPop, .cfgLocked, .SPIIntr
    );

    // Transmit side, fed from the bus
    spiFifo uTxFifo (
        .PCLK, .PRESETn,
        .push(txPush), .pop(txPop), .data(txData),
        .level(txLevel), .full(), .empty(txEmpty)
    );

    // Receive side, flags derived from level in the register block
    spiFifo uRxFifo (
        .PCLK, .PRESETn,
        .push(rxPush), .pop(rxPop), .data(rxData),
        .level(rxLevel), .full(), .empty()
    );

    spiClockGen uClockGen (
        .PCLK, .PRESETn, .sckDiv(cfgLocked.sckDiv), .idle, .tick
    );

    spiEngine uEngine (
        .PCLK, .PRESETn, .cfg(cfgLocked), .tick,
        .txData, .txEmpty, .txPop, .rxPush, .idle,
        .SPICLK, .SPIOut, .SPIIn, .SPICS
    );

endmodule

// File: hdl/spiApb_settings.svh
/*
  Register offsets and reset values for the APB SPI master.
  The delay registers are not implemented and their offsets read as zero.
  FIFO depth and pointer width must stay consistent (depth = 2**ptr).
*/
`ifndef SPI_APB_SETTINGS_SVH
`define SPI_APB_SETTINGS_SVH

// APB byte offsets of the word-aligned registers
`define SPI_ADDR_SCKDIV  8'h00
`define SPI_ADDR_SCKMODE 8'h04
`define SPI_ADDR_CSID    8'h10
`define SPI_ADDR_CSDEF   8'h14
`define SPI_ADDR_CSMODE  8'h18
`define SPI_ADDR_FMT     8'h40
`define SPI_ADDR_TXDATA  8'h48
`define SPI_ADDR_RXDATA  8'h4C
`define SPI_ADDR_TXMARK  8'h50
`define SPI_ADDR_RXMARK  8'h54
`define SPI_ADDR_IE      8'h70
`define SPI_ADDR_IP      8'h74

`define SPI_FIFO_DEPTH   8         // Entries per FIFO
`define SPI_FIFO_PTR_W   3         // log2 of depth
`define SPI_DATA_W       32        // APB data width

`define SPI_SCKDIV_RESET 12'd3     // SCK = PCLK / 8 out of reset
`define SPI_CSDEF_RESET  4'b1111   // All chip selects idle high
`define SPI_LEN_RESET    4'd8      // Full byte frames

`endif

// File: hdl/spiClockGen.sv
/*
  Half-period tick for the SPI engine, one pulse every sckDiv+1 PCLKs.
  Counter is parked at zero while the engine is idle.
*/
`timescale 1ns/1ps

module spiClockGen (
    input  logic            PCLK,
    input  logic            PRESETn,
    input  spiPkg::sckDiv_t sckDiv,
    input  logic            idle,
    output logic            tick
);

    spiPkg::sckDiv_t count;

    // Terminal count, never while parked
    assign tick = ~idle & (count == sckDiv);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            count <= '0;
        end else if (idle || tick) begin
            count <= '0;                    // Restart period
        end else begin
            count <= count + 12'd1;
        end
    end

endmodule

// File: hdl/spiEngine.sv
/*
  SPI frame engine, one state per half SCK period.
  Sample on the Active0 to Active1 step, shift out when leaving Active1.
  pha only moves where SCK toggles. A full RX FIFO drops the byte.
*/
`timescale 1ns/1ps

module spiEngine (
    input  logic               PCLK,
    input  logic               PRESETn,
    input  spiPkg::spiCfg_t    cfg,
    input  logic               tick,
    input  spiPkg::spiByte_t   txData,
    input  logic               txEmpty,
    output logic               txPop,
    output spiPkg::fifoPush_t  rxPush,
    output logic               idle,
    output logic               SPICLK,
    output logic               SPIOut,
    input  logic               SPIIn,
    output spiPkg::csVec_t     SPICS
);

    spiPkg::engineState_t state;
    spiPkg::frameLen_t    bitCnt;               // Bits completed in this frame
    spiPkg::spiByte_t     txShift, rxShift;
    spiPkg::spiByte_t     rxAligned, rxByte;
    spiPkg::csVec_t       csSel;
    logic [3:0]           alignShift;
    logic                 frameActive, lastBit, startFrame, rxPushValid;

    function automatic spiPkg::spiByte_t reverseByte(input spiPkg::spiByte_t b);
        spiPkg::spiByte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7-i];
        end
        return r;
    endfunction

    assign startFrame  = tick & (state == spiPkg::CsIdle) & ~txEmpty;
    assign lastBit     = (bitCnt + 4'd1) >= cfg.len;
    assign frameActive = (state == spiPkg::Lead) || (state == spiPkg::Active0) ||
                         (state == spiPkg::Active1) || (state == spiPkg::Trail);
    assign idle        = (state == spiPkg::CsIdle) & txEmpty;   // Opens the config snapshot

    //////////////////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state       <= spiPkg::CsIdle;
            bitCnt      <= '0;
            txPop       <= 1'b0;
            rxPushValid <= 1'b0;
        end else begin
            txPop       <= startFrame;          // Pop after the load, one cycle
            rxPushValid <= 1'b0;
            if (tick) begin
                case (state)
                    spiPkg::CsIdle:  if (!txEmpty) state <= spiPkg::Lead;
                    spiPkg::Lead: begin
                        bitCnt <= '0;
                        state  <= spiPkg::Active0;
                    end
                    spiPkg::Active0: state <= spiPkg::Active1;
                    spiPkg::Active1: begin
                        bitCnt <= bitCnt + 4'd1;
                        if (lastBit) begin
                            state       <= spiPkg::Trail;
                            rxPushValid <= 1'b1;
                        end else begin
                            state <= spiPkg::Active0;
                        end
                    end
                    spiPkg::Trail:   state <= spiPkg::InterCs;   // CS released next
                    spiPkg::InterCs: state <= spiPkg::CsIdle;
                    default:         state <= spiPkg::CsIdle;
                endcase
            end
        end
    end

    // Shift registers, MSB goes out first after optional reversal
    always_ff @(posedge PCLK) begin
        if (startFrame) begin
            txShift <= cfg.lsbFirst ? reverseByte(txData) : txData;
        end else if (tick && state == spiPkg::Active1) begin
            txShift <= {txShift[6:0], 1'b0};
        end
        if (tick && state == spiPkg::Active0) rxShift <= {rxShift[6:0], SPIIn};
        if (tick && state == spiPkg::Active1 && lastBit) rxByte <= rxAligned;
    end

    // Left align the short frame, then undo the bit order
    assign alignShift = 4'd8 - cfg.len;
    always_comb begin
        rxAligned = rxShift << alignShift[2:0];
        if (cfg.lsbFirst) rxAligned = reverseByte(rxAligned);
    end

    assign rxPush = '{valid: rxPushValid, data: rxByte};

    //////////////////////////////////////////////////////////////
    // Pins
    //////////////////////////////////////////////////////////////

    // SCK leaves its idle level in Active0 for pha 1, in Active1 for pha 0
    assign SPICLK = cfg.pol ^ (cfg.pha ? (state == spiPkg::Active0) : (state == spiPkg::Active1));
    assign SPIOut = frameActive ? txShift[7] : 1'b0;

    assign csSel = 4'b0001 << cfg.csId;
    assign SPICS = (cfg.csMode == spiPkg::CsOff) ? cfg.csDef :
                   (cfg.csDef ^ (frameActive ? csSel : 4'b0000));

    assert property (@(posedge PCLK) disable iff (!PRESETn) $countones(SPICS ^ cfg.csDef) <= 1);

    // Registered pop still sees the loaded entry in the TX FIFO
    assert property (@(posedge PCLK) disable iff (!PRESETn) txPop |-> !txEmpty);

endmodule

// File: hdl/spiFifo.sv
/*
  Byte FIFO, SPI_FIFO_DEPTH entries, same clock on both sides.
  Push to a full FIFO and pop from an empty one are ignored.
  Head entry is always visible on data.
*/
`timescale 1ns/1ps
`include "spiApb_settings.svh"

module spiFifo (
    input  logic               PCLK,
    input  logic               PRESETn,
    input  spiPkg::fifoPush_t  push,
    input  logic               pop,
    output spiPkg::spiByte_t   data,
    output spiPkg::fifoLevel_t level,
    output logic               full,
    output logic               empty
);

    spiPkg::spiByte_t            mem [`SPI_FIFO_DEPTH];
    logic [`SPI_FIFO_PTR_W-1:0]  wrPtr, rdPtr;      // Wrap naturally at depth
    logic                        doPush, doPop;

    assign full   = (level == spiPkg::fifoLevel_t'(`SPI_FIFO_DEPTH));
    assign empty  = (level == '0);
    assign doPush = push.valid & ~full;
    assign doPop  = pop & ~empty;

    // Storage
    always_ff @(posedge PCLK) begin
        if (doPush) mem[wrPtr] <= push.data;
    end

    assign data = mem[rdPtr];   // Show-ahead read

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;            // Both or neither
            endcase
        end
    end

    // Guards above keep the count in range over any push/pop sequence
    assert property (@(posedge PCLK) disable iff (!PRESETn)
        level <= spiPkg::fifoLevel_t'(`SPI_FIFO_DEPTH));

endmodule

// File: hdl/spiPkg.sv
/*
  Shared types for the SPI master. Types only, no logic.
  Frame length is 1 to 8; larger values give undefined data.
*/
`include "spiApb_settings.svh"

package spiPkg;

    typedef logic [7:0]                  regAddr_t;    // APB offset
    typedef logic [`SPI_DATA_W-1:0]      apbData_t;    // Bus word
    typedef logic [7:0]                  spiByte_t;    // Frame payload
    typedef logic [11:0]                 sckDiv_t;     // Divider value
    typedef logic [3:0]                  frameLen_t;   // Bits per frame
    typedef logic [`SPI_FIFO_PTR_W:0]    fifoLevel_t;  // Occupancy 0..depth
    typedef logic [`SPI_FIFO_PTR_W-1:0]  watermark_t;
    typedef logic [3:0]                  csVec_t;      // One bit per chip select

    // Values 1 and 2 are folded into CsAuto on write
    typedef enum logic [1:0] {
        CsAuto = 2'd0,
        CsOff  = 2'd3
    } csMode_t;

    // Each state lasts one half SCK period
    typedef enum logic [2:0] {
        CsIdle, Lead, Active0, Active1, Trail, InterCs
    } engineState_t;

    // Settings seen by the engine, 27 bits
    typedef struct packed {
        sckDiv_t   sckDiv;
        logic      pol;        // SCK idle level
        logic      pha;        // Sample on trailing edge when set
        logic [1:0] csId;
        csVec_t    csDef;
        csMode_t   csMode;
        frameLen_t len;
        logic      lsbFirst;
    } spiCfg_t;

    typedef struct packed {
        logic     valid;
        spiByte_t data;
    } fifoPush_t;

endpackage

// File: hdl/spiRegs.sv
/*
  APB register file. PRDATA is captured in the setup cycle.
  TXDATA writes to a full FIFO are dropped silently.
  Settings reach the engine only while it is idle.
*/
`timescale 1ns/1ps
`include "spiApb_settings.svh"

module spiRegs (
    input  logic               PCLK,
    input  logic               PRESETn,
    input  logic               PSEL,
    input  logic               PENABLE,
    input  logic               PWRITE,
    input  spiPkg::regAddr_t   PADDR,
    input  spiPkg::apbData_t   PWDATA,
    output spiPkg::apbData_t   PRDATA,
    input  spiPkg::fifoLevel_t txLevel,
    input  spiPkg::fifoLevel_t rxLevel,
    input  spiPkg::spiByte_t   rxData,
    input  logic               idle,
    output spiPkg::fifoPush_t  txPush,
    output logic               rxPop,
    output spiPkg::spiCfg_t    cfgLocked,
    output logic               SPIIntr
);

    localparam spiPkg::spiCfg_t CfgReset = '{
        sckDiv:   `SPI_SCKDIV_RESET,
        pol:      1'b0,
        pha:      1'b0,
        csId:     2'd0,
        csDef:    `SPI_CSDEF_RESET,
        csMode:   spiPkg::CsAuto,
        len:      `SPI_LEN_RESET,
        lsbFirst: 1'b0
    };

    spiPkg::spiCfg_t    cfgLive;            // Registers as written by software
    spiPkg::watermark_t txMark, rxMark;
    logic [1:0]         ie, ip;
    spiPkg::regAddr_t   offset;
    spiPkg::apbData_t   readWord;
    logic               wrEn, rdAccess;
    logic               txFull, rxEmpty;

    assign offset   = {PADDR[7:2], 2'b00};            // Word aligned
    assign wrEn     = PSEL & PENABLE & PWRITE;        // Access phase write
    assign rdAccess = PSEL & PENABLE & ~PWRITE;
    assign txFull   = (txLevel == spiPkg::fifoLevel_t'(`SPI_FIFO_DEPTH));
    assign rxEmpty  = (rxLevel == '0);

    //////////////////////////////////////////////////////////////
    // Control register writes
    //////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            cfgLive <= CfgReset;
            txMark  <= '0;
            rxMark  <= '0;
            ie      <= 2'b00;
        end else if (wrEn) begin
            case (offset)
                `SPI_ADDR_SCKDIV:  cfgLive.sckDiv <= PWDATA[11:0];
                `SPI_ADDR_SCKMODE: {cfgLive.pol, cfgLive.pha} <= PWDATA[1:0];
                `SPI_ADDR_CSID:    cfgLive.csId <= PWDATA[1:0];
                `SPI_ADDR_CSDEF:   cfgLive.csDef <= PWDATA[3:0];
                `SPI_ADDR_CSMODE:  cfgLive.csMode <= (PWDATA[1:0] == 2'b11) ?
                                       spiPkg::CsOff : spiPkg::CsAuto;
                `SPI_ADDR_FMT: begin
                    cfgLive.len      <= PWDATA[19:16];
                    cfgLive.lsbFirst <= PWDATA[2];      // Endian bit
                end
                `SPI_ADDR_TXMARK:  txMark <= PWDATA[2:0];
                `SPI_ADDR_RXMARK:  rxMark <= PWDATA[2:0];
                `SPI_ADDR_IE:      ie <= PWDATA[1:0];
                default: ;                              // Read-only or unmapped
            endcase
        end
    end

    // FIFO strobes land one cycle after the access phase
    // A read pops only when the word it returned carried data
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            txPush <= '0;
            rxPop  <= 1'b0;
        end else begin
            txPush.valid <= wrEn & (offset == `SPI_ADDR_TXDATA) & ~txFull;
            txPush.data  <= PWDATA[7:0];
            rxPop        <= rdAccess & (offset == `SPI_ADDR_RXDATA) & ~PRDATA[31];
        end
    end

    // Interlock snapshot is frozen while a frame is in flight
    always_ff @(posedge PCLK) begin
        if (!PRESETn) cfgLocked <= CfgReset;
        else if (idle) cfgLocked <= cfgLive;
    end

    //////////////////////////////////////////////////////////////
    // Watermark interrupts
    //////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            ip <= 2'b00;
        end else begin
            ip[0] <= (txLevel < {1'b0, txMark});   // TX running low
            ip[1] <= (rxLevel > {1'b0, rxMark});   // RX filling up
        end
    end

    assign SPIIntr = |(ip & ie);

    // Read mux
    always_comb begin
        case (offset)
            `SPI_ADDR_SCKDIV:  readWord = {20'b0, cfgLive.sckDiv};
            `SPI_ADDR_SCKMODE: readWord = {30'b0, cfgLive.pol, cfgLive.pha};
            `SPI_ADDR_CSID:    readWord = {30'b0, cfgLive.csId};
            `SPI_ADDR_CSDEF:   readWord = {28'b0, cfgLive.csDef};
            `SPI_ADDR_CSMODE:  readWord = {30'b0, cfgLive.csMode};
            `SPI_ADDR_FMT:     readWord = {12'b0, cfgLive.len, 13'b0, cfgLive.lsbFirst, 2'b0};
            `SPI_ADDR_TXDATA:  readWord = {txFull, 31'b0};
            `SPI_ADDR_RXDATA:  readWord = {rxEmpty, 23'b0, rxData};
            `SPI_ADDR_TXMARK:  readWord = {29'b0, txMark};
            `SPI_ADDR_RXMARK:  readWord = {29'b0, rxMark};
            `SPI_ADDR_IE:      readWord = {30'b0, ie};
            `SPI_ADDR_IP:      readWord = {30'b0, ip};
            default:           readWord = '0;
        endcase
    end

    // Sample in setup so data is stable for the access cycle
    always_ff @(posedge PCLK) begin
        if (PSEL && !PENABLE) PRDATA <= readWord;
    end

    // No pop may reach an RX FIFO that is already empty
    assert property (@(posedge PCLK) disable iff (!PRESETn) rxPop |-> (rxLevel != '0));

endmodule
